/* pdp8Core.f */
+incdir+hw
hw/pdp8Pkg.sv
hw/coreMemory.sv
hw/majorSequencer.sv
hw/instructionDecode.sv
hw/addressUnit.sv
hw/accumulatorPath.sv
hw/pdp8Core.sv
test/pdp8Checker.sv
test/pdp8CoreTb.sv

/* run.sh */
#!/bin/sh
# Build the PDP-8 core testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f pdp8Core.f --top-module pdp8CoreTb -o pdp8Sim \
  && ./obj_dir/pdp8Sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

/* test/pdp8CoreTb.sv */
// Testbench for the PDP-8 core
// Each table entry is loaded at 0200 through the load port and run from there.
// Once the core halts, the checker compares ac, link and pc with the table
`default_nettype none
`timescale 1ns/1ns

module pdp8CoreTb;

  typedef struct packed {
    pdp8Pkg::pdp8Word [0:7] words;
    pdp8Pkg::pdp8Word       expAc;
    logic                   expLink;
    pdp8Pkg::pdp8Addr       expPc;
  } programEntry;

  localparam pdp8Pkg::pdp8Addr LoadBase = 12'o0200;

  logic             clk;
  logic             rst;
  logic             loadEn;
  pdp8Pkg::pdp8Addr loadAddr;
  pdp8Pkg::pdp8Word loadData;
  logic             run;
  pdp8Pkg::pdp8Addr startAddr;
  logic             halted;
  pdp8Pkg::pdp8Addr pc;
  pdp8Pkg::pdp8Word ac;
  logic             link;
  logic             check;
  pdp8Pkg::pdp8Word expAc;
  logic             expLink;
  pdp8Pkg::pdp8Addr expPc;
  int               errCount;
  int               checkCount;
  programEntry      programs[$];
  int               cycles = 0;
  int               cycleLimit = 0;

  pdp8Core u_dut (
    .clk       (clk),
    .rst       (rst),
    .loadEn    (loadEn),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .run       (run),
    .startAddr (startAddr),
    .halted    (halted),
    .pc        (pc),
    .ac        (ac),
    .link      (link)
  );

  pdp8Checker u_checker (
    .clk        (clk),
    .check      (check),
    .halted     (halted),
    .pc         (pc),
    .ac         (ac),
    .link       (link),
    .expAc      (expAc),
    .expLink    (expLink),
    .expPc      (expPc),
    .errCount   (errCount),
    .checkCount (checkCount)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic waitCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic addProgram(input pdp8Pkg::pdp8Word [0:7] words,
                            input pdp8Pkg::pdp8Word acVal, input logic linkVal,
                            input pdp8Pkg::pdp8Addr pcVal);
    programEntry entry;
    entry.words   = words;
    entry.expAc   = acVal;
    entry.expLink = linkVal;
    entry.expPc   = pcVal;
    programs.push_back(entry);
  endtask

  task automatic buildTable();
    // TAD twice, AND a mask, store with DCA and reload
    addProgram({12'o1206, 12'o1206, 12'o0207, 12'o3206,
                12'o1206, 12'o7402, 12'o1234, 12'o7070}, 12'o2070, 1'b0, 12'o0206);
    // 7777 plus 3 carries into the link
    addProgram({12'o1203, 12'o1204, 12'o7402, 12'o7777,
                12'o0003, 12'o0000, 12'o0000, 12'o0000}, 12'o0002, 1'b1, 12'o0203);
    // ISZ counter from 7775, one TAD per pass
    addProgram({12'o1206, 12'o2207, 12'o5200, 12'o7402,
                12'o0000, 12'o0000, 12'o0001, 12'o7775}, 12'o0003, 1'b0, 12'o0204);
    // JMS to 0204, read back the return address, JMP I 0204 back to the HLT
    addProgram({12'o4204, 12'o7402, 12'o0000, 12'o0000,
                12'o0000, 12'o1204, 12'o5604, 12'o0000}, 12'o0201, 1'b0, 12'o0202);
    // CLA CLL CMA IAC
    addProgram({12'o7341, 12'o7402, 12'o0000, 12'o0000,
                12'o0000, 12'o0000, 12'o0000, 12'o0000}, 12'o0000, 1'b1, 12'o0202);
    // Same, then RAL, add 6 and RTR
    addProgram({12'o7341, 12'o7004, 12'o1206, 12'o7012,
                12'o7402, 12'o0000, 12'o0006, 12'o0000}, 12'o4001, 1'b1, 12'o0205);
    // Skip tests load a value, skip, then a marker TAD of 0100 and HLT
    // SZA taken and not taken
    addProgram({12'o1205, 12'o7440, 12'o1206, 12'o7402,
                12'o0000, 12'o0000, 12'o0100, 12'o0000}, 12'o0000, 1'b0, 12'o0204);
    addProgram({12'o1205, 12'o7440, 12'o1206, 12'o7402,
                12'o0000, 12'o0005, 12'o0100, 12'o0000}, 12'o0105, 1'b0, 12'o0204);
    // SNA
    addProgram({12'o1205, 12'o7450, 12'o1206, 12'o7402,
                12'o0000, 12'o0005, 12'o0100, 12'o0000}, 12'o0005, 1'b0, 12'o0204);
    addProgram({12'o1205, 12'o7450, 12'o1206, 12'o7402,
                12'o0000, 12'o0000, 12'o0100, 12'o0000}, 12'o0100, 1'b0, 12'o0204);
    // SMA
    addProgram({12'o1205, 12'o7500, 12'o1206, 12'o7402,
                12'o0000, 12'o4000, 12'o0100, 12'o0000}, 12'o4000, 1'b0, 12'o0204);
    addProgram({12'o1205, 12'o7500, 12'o1206, 12'o7402,
                12'o0000, 12'o0003, 12'o0100, 12'o0000}, 12'o0103, 1'b0, 12'o0204);
    // SNL after CML, then after CLL
    addProgram({12'o7020, 12'o7420, 12'o1206, 12'o7402,
                12'o0000, 12'o0000, 12'o0100, 12'o0000}, 12'o0000, 1'b1, 12'o0204);
    addProgram({12'o7100, 12'o7420, 12'o1206, 12'o7402,
                12'o0000, 12'o0000, 12'o0100, 12'o0000}, 12'o0100, 1'b0, 12'o0204);
  endtask

  task automatic resetDut();
    rst = 1'b1;
    repeat (3) waitCycle();
    rst = 1'b0;
  endtask

  task automatic requestCheck(input pdp8Pkg::pdp8Word acVal, input logic linkVal,
                              input pdp8Pkg::pdp8Addr pcVal);
    expAc   = acVal;
    expLink = linkVal;
    expPc   = pcVal;
    check   = 1'b1;
    waitCycle();
    check   = 1'b0;
  endtask

  task automatic runProgram(input programEntry prog);
    int w;
    for (w = 0; w < 8; w++) begin
      loadEn   = 1'b1;
      loadAddr = LoadBase + 12'(w);
      loadData = prog.words[w];
      waitCycle();
    end
    loadEn    = 1'b0;
    startAddr = LoadBase;
    run       = 1'b1;
    waitCycle();
    run = 1'b0;
    // Core is in fetch by now, so halted is low until the HLT
    waitCycle();
    while (!halted) begin
      waitCycle();
    end
  endtask

  initial begin
    int t;
    rst       = 1'b1;
    loadEn    = 1'b0;
    loadAddr  = '0;
    loadData  = '0;
    run       = 1'b0;
    startAddr = '0;
    check     = 1'b0;
    expAc     = '0;
    expLink   = 1'b0;
    expPc     = '0;
    buildTable();
    cycleLimit = programs.size() * 8 * 3 + 200;
    for (t = 0; t < programs.size(); t++) begin
      resetDut();
      // Reset state first, then the program result
      requestCheck(12'o0000, 1'b0, 12'o0000);
      runProgram(programs[t]);
      requestCheck(programs[t].expAc, programs[t].expLink, programs[t].expPc);
    end
    waitCycle();
    $display("Checks done: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    @(posedge clk);
    while (cycles <= cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the program table did not finish within %0d cycles", cycleLimit);
    $display("Checks done: %0d checks, %0d errors", checkCount, errCount);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/pdp8Checker.sv */
// Result checker for the PDP-8 core testbench
// On each cycle with check high it compares the core outputs with the
// expected ac, link and pc and counts every mismatch
`default_nettype none
`timescale 1ns/1ns

module pdp8Checker (
  input  wire logic              clk,
  input  wire logic              check,
  input  wire logic              halted,
  input  wire pdp8Pkg::pdp8Addr  pc,
  input  wire pdp8Pkg::pdp8Word  ac,
  input  wire logic              link,
  input  wire pdp8Pkg::pdp8Word  expAc,
  input  wire logic              expLink,
  input  wire pdp8Pkg::pdp8Addr  expPc,
  output int                     errCount,
  output int                     checkCount
);

  int errs = 0;
  int checks = 0;

  assign errCount   = errs;
  assign checkCount = checks;

  task automatic compareField(input string name, input logic [11:0] got,
                              input logic [11:0] want);
    if (got !== want) begin
      errs++;
      $display("Error at %0t ns: %s is %04o, expected %04o", $time, name, got, want);
    end
  endtask

  // Mid cycle, well clear of the DUT's clock edge
  always @(negedge clk) begin
    if (check) begin
      checks++;
      if (halted !== 1'b1) begin
        errs++;
        $display("Error at %0t ns: halted is %b, expected 1", $time, halted);
      end
      compareField("ac", ac, expAc);
      compareField("link", {11'b0, link}, {11'b0, expLink});
      compareField("pc", pc, expPc);
    end
  end

endmodule

`default_nettype wire

/* hw/pdp8Core.sv */
// PDP-8 processor top level with its core memory
// Load programs through the load port while halted, then pulse run with
// the start address; halted rises again once an HLT has executed
`default_nettype none
`timescale 1ns/1ns

module pdp8Core (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              loadEn,
  input  wire pdp8Pkg::pdp8Addr  loadAddr,
  input  wire pdp8Pkg::pdp8Word  loadData,
  input  wire logic              run,
  input  wire pdp8Pkg::pdp8Addr  startAddr,
  output logic                   halted,
  output pdp8Pkg::pdp8Addr       pc,
  output pdp8Pkg::pdp8Word       ac,
  output logic                   link
);

  pdp8Pkg::decodedInstr instr;
  pdp8Pkg::majorState   state;
  pdp8Pkg::memPort      memBus;
  pdp8Pkg::pdp8Word     readData;
  logic                 skip;

  coreMemory theMemory (
    .clk      (clk),
    .port     (memBus),
    .readData (readData)
  );

  majorSequencer theSequencer (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .instr  (instr),
    .state  (state),
    .halted (halted)
  );

  instructionDecode theDecode (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .readData (readData),
    .instr    (instr)
  );

  addressUnit theAddress (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .instr     (instr),
    .readData  (readData),
    .startAddr (startAddr),
    .run       (run),
    .acWord    (ac),
    .skip      (skip),
    .loadEn    (loadEn),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .mem       (memBus),
    .pc        (pc)
  );

  accumulatorPath theAccumulator (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .instr    (instr),
    .readData (readData),
    .ac       (ac),
    .link     (link),
    .skip     (skip)
  );

endmodule

`default_nettype wire

/* hw/accumulatorPath.sv */
// Accumulator and link of the PDP-8 processor
// Executes AND, TAD and DCA on the AC, runs the group 1 operate chain
// and evaluates the group 2 skip condition
`default_nettype none
`timescale 1ns/1ns

`include "pdp8_macros.svh"

module accumulatorPath (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire pdp8Pkg::majorState    state,
  input  wire pdp8Pkg::decodedInstr  instr,
  input  wire pdp8Pkg::pdp8Word      readData,
  output pdp8Pkg::pdp8Word           ac,
  output logic                       link,
  output logic                       skip
);

  logic [`WORD_BITS:0] sum;
  pdp8Pkg::pdp8Word    opAc;
  logic                opLink;
  logic                iacCarry;
  logic [`WORD_BITS:0] rot;
  logic                testHit;

  // Carry out of TAD lands in bit 12
  assign sum = {1'b0, ac} + {1'b0, readData};

  // Group 1 sequence: clear, complement, increment, rotate
  always_comb begin
    opAc     = instr.cla ? '0 : ac;
    opLink   = instr.cll ? 1'b0 : link;
    iacCarry = 1'b0;
    if (instr.cma) begin
      opAc = ~opAc;
    end
    if (instr.cml) begin
      opLink = ~opLink;
    end
    if (instr.iac) begin
      {iacCarry, opAc} = {1'b0, opAc} + 1'b1;
    end
    if (iacCarry) begin
      opLink = ~opLink;
    end
    // Link sits above AC bit 11 while rotating
    rot = {opLink, opAc};
    if (instr.rar) begin
      rot = {rot[0], rot[`WORD_BITS:1]};
      if (instr.twice) begin
        rot = {rot[0], rot[`WORD_BITS:1]};
      end
    end else if (instr.ral) begin
      rot = {rot[`WORD_BITS-1:0], rot[`WORD_BITS]};
      if (instr.twice) begin
        rot = {rot[`WORD_BITS-1:0], rot[`WORD_BITS]};
      end
    end
  end

  // Tested against AC before any group 2 CLA
  assign testHit = (instr.sma & ac[`WORD_BITS-1]) |
                   (instr.sza & (ac == '0)) |
                   (instr.snl & link);
  assign skip    = instr.grp2 & (testHit ^ instr.invert);

  always_ff @(posedge clk) begin
    if (rst) begin
      ac   <= '0;
      link <= 1'b0;
    end else if (state == pdp8Pkg::stExecute) begin
      case (instr.opcode)
        pdp8Pkg::opAnd: ac <= ac & readData;
        pdp8Pkg::opTad: begin
          ac <= sum[`WORD_BITS-1:0];
          if (sum[`WORD_BITS]) begin
            link <= ~link;
          end
        end
        // Store happens on this same edge
        pdp8Pkg::opDca: ac <= '0;
        pdp8Pkg::opOpr: begin
          if (instr.grp1) begin
            ac   <= rot[`WORD_BITS-1:0];
            link <= rot[`WORD_BITS];
          end else if (instr.grp2 & instr.cla) begin
            ac <= '0;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/addressUnit.sv */
// Program counter, effective address and memory port control
// Owns the memory port while running and hands it to the load port in idle.
// Performs the stores of DCA, JMS and ISZ and the jumps and skips on the PC
`default_nettype none
`timescale 1ns/1ns

`include "pdp8_macros.svh"

module addressUnit (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire pdp8Pkg::majorState    state,
  input  wire pdp8Pkg::decodedInstr  instr,
  input  wire pdp8Pkg::pdp8Word      readData,
  input  wire pdp8Pkg::pdp8Addr      startAddr,
  input  wire logic                  run,
  input  wire pdp8Pkg::pdp8Word      acWord,
  input  wire logic                  skip,
  input  wire logic                  loadEn,
  input  wire pdp8Pkg::pdp8Addr      loadAddr,
  input  wire pdp8Pkg::pdp8Word      loadData,
  output pdp8Pkg::memPort            mem,
  output pdp8Pkg::pdp8Addr           pc
);

  pdp8Pkg::pdp8Addr ea;
  pdp8Pkg::pdp8Addr directAddr;
  pdp8Pkg::pdp8Addr returnAddr;
  pdp8Pkg::pdp8Word iszWord;
  logic             iszZero;
  logic             skipNext;

  // Page of the instruction itself, or page zero
  assign directAddr = instr.curPage ?
                      {pc[`ADDR_BITS-1 -: `PAGE_BITS], instr.offset} :
                      {{`PAGE_BITS{1'b0}}, instr.offset};

  // PC already points past the JMS here
  assign returnAddr = pc;
  assign iszWord    = readData + 1'b1;
  assign iszZero    = (iszWord == '0);
  assign skipNext   = skip | ((instr.opcode == pdp8Pkg::opIsz) & iszZero);

  always_ff @(posedge clk) begin
    if (state == pdp8Pkg::stFetch) begin
      ea <= directAddr;
    end else if (state == pdp8Pkg::stDefer) begin
      ea <= readData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      case (state)
        pdp8Pkg::stIdle: begin
          if (run) begin
            pc <= startAddr;
          end
        end
        pdp8Pkg::stFetch: begin
          pc <= pc + 1'b1;
        end
        pdp8Pkg::stExecute: begin
          if (instr.opcode == pdp8Pkg::opJms) begin
            pc <= ea + 1'b1;
          end else if (instr.opcode == pdp8Pkg::opJmp) begin
            pc <= ea;
          end else if (skipNext) begin
            pc <= pc + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    mem.we   = 1'b0;
    mem.addr = ea;
    mem.data = acWord;
    case (state)
      pdp8Pkg::stIdle: begin
        mem.we   = loadEn;
        mem.addr = loadAddr;
        mem.data = loadData;
      end
      pdp8Pkg::stFetch: begin
        mem.addr = pc;
      end
      pdp8Pkg::stExecute: begin
        case (instr.opcode)
          pdp8Pkg::opDca: mem.we = 1'b1;
          pdp8Pkg::opJms: begin
            mem.we   = 1'b1;
            mem.data = returnAddr;
          end
          pdp8Pkg::opIsz: begin
            mem.we   = 1'b1;
            mem.data = iszWord;
          end
          default: begin
          end
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/instructionDecode.sv */
// Instruction register and field decode for the PDP-8 processor
// During fetch the word on the memory bus is decoded directly, so the
// sequencer and the address unit see the new instruction in that cycle
`default_nettype none
`timescale 1ns/1ns

`include "pdp8_macros.svh"

module instructionDecode (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire pdp8Pkg::majorState  state,
  input  wire pdp8Pkg::pdp8Word    readData,
  output pdp8Pkg::decodedInstr     instr
);

  pdp8Pkg::pdp8Word ir;
  pdp8Pkg::pdp8Word word;
  pdp8Pkg::opcodeT  opcode;
  logic             memRef;
  logic             isOpr;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir <= '0;
    end else if (state == pdp8Pkg::stFetch) begin
      ir <= readData;
    end
  end

  assign word   = (state == pdp8Pkg::stFetch) ? readData : ir;
  assign opcode = pdp8Pkg::opcodeT'(word[`WORD_BITS-1 -: 3]);
  assign memRef = (opcode < pdp8Pkg::opIot);
  assign isOpr  = (opcode == pdp8Pkg::opOpr);

  always_comb begin
    instr          = '0;
    instr.opcode   = opcode;
    instr.indirect = memRef & word[`INDIRECT_BIT];
    instr.curPage  = word[`CURPAGE_BIT];
    instr.offset   = word[`OFFSET_BITS-1:0];
    // Group 3 (bits 8 and 0 set) falls through as a no-op
    instr.grp1     = isOpr & ~word[8];
    instr.grp2     = isOpr & word[8] & ~word[0];
    instr.cla      = (instr.grp1 | instr.grp2) & word[7];
    instr.cll      = instr.grp1 & word[6];
    instr.cma      = instr.grp1 & word[5];
    instr.cml      = instr.grp1 & word[4];
    instr.rar      = instr.grp1 & word[3];
    instr.ral      = instr.grp1 & word[2];
    instr.twice    = instr.grp1 & word[1];
    instr.iac      = instr.grp1 & word[0];
    instr.sma      = instr.grp2 & word[6];
    instr.sza      = instr.grp2 & word[5];
    instr.snl      = instr.grp2 & word[4];
    instr.invert   = instr.grp2 & word[3];
    instr.hlt      = instr.grp2 & word[1];
  end

endmodule

`default_nettype wire

/* hw/majorSequencer.sv */
// Major state sequencer of the PDP-8 processor
// Steps one instruction at a time through fetch, an optional defer and execute.
// Sits in idle after reset or an executed HLT until a run pulse arrives
`default_nettype none
`timescale 1ns/1ns

module majorSequencer (
  input  wire logic                  clk,
  input  wire logic                  rst,
  // Start pulse, only looked at in idle
  input  wire logic                  run,
  input  wire pdp8Pkg::decodedInstr  instr,
  output pdp8Pkg::majorState         state,
  output logic                       halted
);

  pdp8Pkg::majorState nextState;

  always_comb begin
    nextState = state;
    case (state)
      pdp8Pkg::stIdle: begin
        if (run) begin
          nextState = pdp8Pkg::stFetch;
        end
      end
      pdp8Pkg::stFetch: begin
        // Indirect flag is only ever set on memory reference words
        if (instr.indirect) begin
          nextState = pdp8Pkg::stDefer;
        end else begin
          nextState = pdp8Pkg::stExecute;
        end
      end
      pdp8Pkg::stDefer: begin
        nextState = pdp8Pkg::stExecute;
      end
      pdp8Pkg::stExecute: begin
        // HLT is decoded for group 2 only
        if (instr.hlt) begin
          nextState = pdp8Pkg::stIdle;
        end else begin
          nextState = pdp8Pkg::stFetch;
        end
      end
      default: begin
        nextState = pdp8Pkg::stIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= pdp8Pkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  // Idle is the halted condition
  assign halted = (state == pdp8Pkg::stIdle);

endmodule

`default_nettype wire

/* hw/coreMemory.sv */
// Word addressed core memory for the PDP-8
// Reads are combinational for the presented address, writes land on the clock edge
// A depth below 4K simply wraps the address
`default_nettype none
`timescale 1ns/1ns

`include "pdp8_macros.svh"

module coreMemory #(
  parameter int MemWords = `MEM_WORDS
) (
  input  wire logic             clk,
  input  wire pdp8Pkg::memPort  port,
  output pdp8Pkg::pdp8Word      readData
);

  localparam int IdxBits = $clog2(MemWords);

  logic [`WORD_BITS-1:0] mem [MemWords];
  logic [IdxBits-1:0]    idx;

  // Upper address bits ignored for small memories
  assign idx = port.addr[IdxBits-1:0];

  always_ff @(posedge clk) begin
    if (port.we) begin
      mem[idx] <= port.data;
    end
  end

  assign readData = mem[idx];

endmodule

`default_nettype wire

/* hw/pdp8Pkg.sv */
// Types shared between the PDP-8 processor blocks
// Members are referenced as pdp8Pkg::name, widths come from the macros header
`default_nettype none

`include "pdp8_macros.svh"

package pdp8Pkg;

  typedef logic [`WORD_BITS-1:0]   pdp8Word;
  typedef logic [`ADDR_BITS-1:0]   pdp8Addr;
  typedef logic [`OFFSET_BITS-1:0] pageOffset;

  // Top three bits of an instruction
  typedef enum logic [2:0] {
    opAnd = 3'd0,
    opTad = 3'd1,
    opIsz = 3'd2,
    opDca = 3'd3,
    opJms = 3'd4,
    opJmp = 3'd5,
    opIot = 3'd6,
    opOpr = 3'd7
  } opcodeT;

  typedef enum logic [1:0] {
    stIdle,
    stFetch,
    stDefer,
    stExecute
  } majorState;

  typedef struct packed {
    opcodeT    opcode;
    // Set only for memory reference words
    logic      indirect;
    logic      curPage;
    pageOffset offset;
    logic      grp1;
    logic      grp2;
    // Clear AC, used by both operate groups
    logic      cla;
    logic      cll;
    logic      cma;
    logic      cml;
    logic      iac;
    logic      rar;
    logic      ral;
    logic      twice;
    logic      sma;
    logic      sza;
    logic      snl;
    logic      invert;
    logic      hlt;
  } decodedInstr;

  typedef struct packed {
    logic    we;
    pdp8Addr addr;
    pdp8Word data;
  } memPort;

endpackage

`default_nettype wire

/* hw/pdp8_macros.svh */
// Widths and instruction field positions shared by the PDP-8 core
// Include this header wherever a width or a bit index is needed
`ifndef PDP8_MACROS_SVH
`define PDP8_MACROS_SVH

// Machine word and address widths
`define WORD_BITS   12
`define ADDR_BITS   12

// An address is a page number joined with an in-page offset
`define OFFSET_BITS 7
`define PAGE_BITS   5

// Full 4K word core
`define MEM_WORDS   4096

// Addressing flags of a memory reference instruction
`define INDIRECT_BIT 8
`define CURPAGE_BIT  7

`endif
